/* fetch_decode.f */
+incdir+include
logic/fd_pkg.sv
logic/warp_pc_file.sv
logic/two_grant_arbiter.sv
logic/imem_loader.sv
logic/instr_mem.sv
logic/slot_reg.sv
logic/instr_decoder.sv
logic/fetch_decode.sv
test/fetch_decode_tb.sv

/* include/fd_cfg.svh */
`ifndef FD_CFG_SVH
`define FD_CFG_SVH

// Warps held by the front end
`define FD_WARPS 8

// Instruction memory in 32-bit words
`define FD_IMEM_AW 10
`define FD_IMEM_DEPTH 1024

`endif

/* logic/fd_pkg.sv */
`default_nettype none
`include "fd_cfg.svh"

package fd_pkg;

	// Field layout opcode [31:26] dst [25:21] src1 [20:16] src2 [15:11] imm [15:0]
	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_ADDI = 6'h05,
		OP_LW   = 6'h06,
		OP_SW   = 6'h07,
		OP_BEQ  = 6'h08,
		OP_BLT  = 6'h09,
		OP_EXIT = 6'h0a
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_NOP = 4'h0,
		ALU_ADD = 4'h1,
		ALU_SUB = 4'h2,
		ALU_AND = 4'h3,
		ALU_OR  = 4'h4
	} alu_op_e;

	typedef struct packed {
		alu_op_e     alu_op;
		logic [4:0]  dst;
		logic [4:0]  src1;
		logic [4:0]  src2;
		logic [15:0] imm;
		logic        src1_valid;
		logic        src2_valid;
		logic        imm_valid;
		logic        reg_write;
		logic        mem_read;
		logic        mem_write;
		logic        beq;
		logic        blt;
		logic        exit;
	} decoded_t;

	typedef struct packed {
		logic                 valid;
		logic [`FD_WARPS-1:0] warp; // One-hot
		logic [31:0]          pc;
	} fetch_t;

	typedef struct packed {
		logic                 valid;
		logic [`FD_WARPS-1:0] warp; // One-hot
		logic [31:0]          pc_plus4;
		logic [31:0]          instr;
		decoded_t             dec;
	} issue_t;

	typedef struct packed {
		logic [$clog2(`FD_WARPS)-1:0] warp;
		logic [31:0]                  pc;
	} launch_t;

	typedef struct packed {
		logic [`FD_IMEM_AW-1:0] addr; // Word address
		logic [31:0]            data;
	} imem_wr_t;

endpackage

`default_nettype wire

/* logic/fetch_decode.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fd_cfg.svh"

module fetch_decode (
	input wire clk,
	input wire rst_n,
	input wire load_req,
	input wire fd_pkg::imem_wr_t load,
	output logic load_ack,
	input wire launch_valid,
	input wire fd_pkg::launch_t launch,
	input wire [`FD_WARPS-1:0] stall,
	input wire [`FD_WARPS-1:0] ib_req,
	output fd_pkg::issue_t out0,
	output fd_pkg::issue_t out1
);

	logic [`FD_WARPS-1:0] elig;
	logic [`FD_WARPS-1:0][31:0] pc;
	logic [`FD_WARPS-1:0] grant [2];
	logic wr_en;
	fd_pkg::imem_wr_t wr;
	logic [`FD_IMEM_AW-1:0] raddr [2];
	logic [31:0] rdata [2];
	fd_pkg::fetch_t fetch_d [2];
	fd_pkg::fetch_t fetch_q [2];
	fd_pkg::decoded_t dec [2];
	fd_pkg::issue_t issue_d [2];
	fd_pkg::issue_t issue_q [2];

	warp_pc_file pc_file_i (
		.clk(clk),
		.rst_n(rst_n),
		.launch_valid(launch_valid),
		.launch(launch),
		.grant0(grant[0]),
		.grant1(grant[1]),
		.stall(stall),
		.ib_req(ib_req),
		.done0(issue_d[0]), // Retires in the edge that registers out0
		.done1(issue_d[1]),
		.elig(elig),
		.pc(pc)
	);

	two_grant_arbiter arb_i (
		.clk(clk),
		.rst_n(rst_n),
		.elig(elig),
		.grant0(grant[0]),
		.grant1(grant[1])
	);

	imem_loader loader_i (
		.clk(clk),
		.rst_n(rst_n),
		.load_req(load_req),
		.load(load),
		.load_ack(load_ack),
		.wr_en(wr_en),
		.wr(wr)
	);

	instr_mem imem_i (
		.clk(clk),
		.wr_en(wr_en),
		.wr(wr),
		.raddr0(raddr[0]),
		.raddr1(raddr[1]),
		.rdata0(rdata[0]),
		.rdata1(rdata[1])
	);

	for (genvar s = 0; s < 2; s++) begin : g_slot
		logic [31:0] sel_pc;

		// One-hot PC select
		always_comb begin
			sel_pc = '0;
			for (int w = 0; w < `FD_WARPS; w++) begin
				if (grant[s][w])
					sel_pc = sel_pc | pc[w];
			end
		end

		assign raddr[s] = sel_pc[`FD_IMEM_AW+1:2]; // Byte PC to word
		assign fetch_d[s] = '{valid: |grant[s], warp: grant[s], pc: sel_pc};

		slot_reg #(.payload_t(fd_pkg::fetch_t)) fetch_reg_i (
			.clk(clk),
			.rst_n(rst_n),
			.d(fetch_d[s]),
			.q(fetch_q[s])
		);

		instr_decoder dec_i (
			.instr(rdata[s]),
			.dec(dec[s])
		);

		assign issue_d[s] = '{
			valid: fetch_q[s].valid,
			warp: fetch_q[s].warp,
			pc_plus4: fetch_q[s].pc + 32'd4,
			instr: rdata[s],
			dec: dec[s]
		};

		slot_reg #(.payload_t(fd_pkg::issue_t)) issue_reg_i (
			.clk(clk),
			.rst_n(rst_n),
			.d(issue_d[s]),
			.q(issue_q[s])
		);
	end

	assign out0 = issue_q[0];
	assign out1 = issue_q[1];

endmodule

`default_nettype wire

/* logic/imem_loader.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fd_cfg.svh"

module imem_loader (
	input wire clk,
	input wire rst_n,
	input wire load_req,
	input wire fd_pkg::imem_wr_t load,
	output logic load_ack,
	output logic wr_en,
	output fd_pkg::imem_wr_t wr
);

	typedef enum logic {
		S_IDLE,
		S_ACK
	} state_e;

	state_e state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (load_req) state <= S_ACK;
				S_ACK: if (!load_req) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	assign load_ack = (state == S_ACK);

	// One strobe per request phase
	assign wr_en = load_req && (state == S_IDLE);
	assign wr = load; // Requester holds load stable

endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
	input wire [31:0] instr,
	output fd_pkg::decoded_t dec
);

	fd_pkg::opcode_e op;

	assign op = fd_pkg::opcode_e'(instr[31:26]);

	always_comb begin
		dec = '0;
		dec.dst = instr[25:21];
		dec.src1 = instr[20:16];
		dec.src2 = instr[15:11];
		dec.imm = instr[15:0]; // Overlaps src2
		case (op)
			fd_pkg::OP_ADD: begin
				dec.alu_op = fd_pkg::ALU_ADD;
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1;
				dec.reg_write = 1'b1;
			end
			fd_pkg::OP_SUB: begin
				dec.alu_op = fd_pkg::ALU_SUB;
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1;
				dec.reg_write = 1'b1;
			end
			fd_pkg::OP_AND: begin
				dec.alu_op = fd_pkg::ALU_AND;
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1;
				dec.reg_write = 1'b1;
			end
			fd_pkg::OP_OR: begin
				dec.alu_op = fd_pkg::ALU_OR;
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1;
				dec.reg_write = 1'b1;
			end
			fd_pkg::OP_ADDI: begin
				dec.alu_op = fd_pkg::ALU_ADD;
				dec.src1_valid = 1'b1;
				dec.imm_valid = 1'b1;
				dec.reg_write = 1'b1;
			end
			fd_pkg::OP_LW: begin
				dec.alu_op = fd_pkg::ALU_ADD; // Address calc
				dec.src1_valid = 1'b1;
				dec.imm_valid = 1'b1;
				dec.reg_write = 1'b1;
				dec.mem_read = 1'b1;
			end
			fd_pkg::OP_SW: begin
				dec.alu_op = fd_pkg::ALU_ADD;
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1; // Store data
				dec.imm_valid = 1'b1;
				dec.mem_write = 1'b1;
			end
			fd_pkg::OP_BEQ: begin
				dec.alu_op = fd_pkg::ALU_SUB; // Compare
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1;
				dec.imm_valid = 1'b1;
				dec.beq = 1'b1;
			end
			fd_pkg::OP_BLT: begin
				dec.alu_op = fd_pkg::ALU_SUB;
				dec.src1_valid = 1'b1;
				dec.src2_valid = 1'b1;
				dec.imm_valid = 1'b1;
				dec.blt = 1'b1;
			end
			fd_pkg::OP_EXIT: dec.exit = 1'b1;
			default: ; // NOP and unknown opcodes
		endcase
	end

endmodule

`default_nettype wire

/* logic/instr_mem.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fd_cfg.svh"

module instr_mem (
	input wire clk,
	input wire wr_en,
	input wire fd_pkg::imem_wr_t wr,
	input wire [`FD_IMEM_AW-1:0] raddr0,
	input wire [`FD_IMEM_AW-1:0] raddr1,
	output logic [31:0] rdata0,
	output logic [31:0] rdata1
);

	logic [31:0] mem [`FD_IMEM_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr.addr] <= wr.data;
		// Read-first on a colliding address
		rdata0 <= mem[raddr0];
		rdata1 <= mem[raddr1];
	end

endmodule

`default_nettype wire

/* logic/slot_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module slot_reg #(
	parameter type payload_t = logic
) (
	input wire clk,
	input wire rst_n,
	input wire payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			q <= '0; // Valid low out of reset
		else
			q <= d;
	end

endmodule

`default_nettype wire

/* logic/two_grant_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fd_cfg.svh"

module two_grant_arbiter (
	input wire clk,
	input wire rst_n,
	input wire [`FD_WARPS-1:0] elig,
	output logic [`FD_WARPS-1:0] grant0,
	output logic [`FD_WARPS-1:0] grant1
);

	localparam int PW = $clog2(`FD_WARPS);

	logic [PW-1:0] ptr;
	logic [PW-1:0] ptr_next;

	// Circular scan from ptr, first two hits win
	always_comb begin
		int w;
		logic hit0;
		logic hit1;
		w = 0;
		hit0 = 1'b0;
		hit1 = 1'b0;
		grant0 = '0;
		grant1 = '0;
		ptr_next = ptr;
		for (int k = 0; k < `FD_WARPS; k++) begin
			w = (int'(ptr) + k) % `FD_WARPS;
			if (elig[w]) begin
				if (!hit0) begin
					grant0[w] = 1'b1;
					hit0 = 1'b1;
					ptr_next = PW'((w + 1) % `FD_WARPS);
				end else if (!hit1) begin
					grant1[w] = 1'b1;
					hit1 = 1'b1;
					ptr_next = PW'((w + 1) % `FD_WARPS); // Past the last grant
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ptr <= '0;
		else
			ptr <= ptr_next; // Holds when nothing eligible
	end

endmodule

`default_nettype wire

/* logic/warp_pc_file.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fd_cfg.svh"

module warp_pc_file (
	input wire clk,
	input wire rst_n,
	input wire launch_valid,
	input wire fd_pkg::launch_t launch,
	input wire [`FD_WARPS-1:0] grant0,
	input wire [`FD_WARPS-1:0] grant1,
	input wire [`FD_WARPS-1:0] stall,
	input wire [`FD_WARPS-1:0] ib_req,
	input wire fd_pkg::issue_t done0,
	input wire fd_pkg::issue_t done1,
	output logic [`FD_WARPS-1:0] elig,
	output logic [`FD_WARPS-1:0][31:0] pc
);

	logic [`FD_WARPS-1:0] active;
	logic [`FD_WARPS-1:0] in_flight;
	logic [`FD_WARPS-1:0] start;
	logic [`FD_WARPS-1:0] granted;
	logic [`FD_WARPS-1:0] retire;
	logic [`FD_WARPS-1:0] kill;

	// Warp index to one-hot
	assign start = launch_valid ?
		({{(`FD_WARPS-1){1'b0}}, 1'b1} << launch.warp) : '0;

	assign granted = grant0 | grant1;

	// Slots leaving decode this cycle
	assign retire = ({`FD_WARPS{done0.valid}} & done0.warp) |
		({`FD_WARPS{done1.valid}} & done1.warp);
	assign kill = ({`FD_WARPS{done0.valid & done0.dec.exit}} & done0.warp) |
		({`FD_WARPS{done1.valid & done1.dec.exit}} & done1.warp);

	assign elig = active & ib_req & ~stall & ~in_flight;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= '0;
			in_flight <= '0;
		end else begin
			active <= start | (active & ~kill); // Launch wins over exit
			in_flight <= ~start & (granted | (in_flight & ~retire));
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < `FD_WARPS; w++) begin
			if (start[w])
				pc[w] <= launch.pc;
			else if (granted[w])
				pc[w] <= pc[w] + 32'd4; // Sequential only
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f fetch_decode.f --top-module fetch_decode_tb -o sim_fetch_decode
./obj_dir/sim_fetch_decode > sim.log
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation passed"

/* test/fetch_decode_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fd_cfg.svh"

module fetch_decode_tb;

	localparam int LOAD_CYC = `FD_IMEM_DEPTH * 5;
	localparam int RUN_CYC = 300;
	localparam int MASK_CYC = 400;
	localparam int EXIT_CYC = 400;
	localparam int LIMIT = 2 * (10 + LOAD_CYC + 3 * 10 + RUN_CYC + MASK_CYC + EXIT_CYC + 10);
	localparam int WW = $clog2(`FD_WARPS);

	logic clk;
	logic rst_n;
	logic load_req;
	fd_pkg::imem_wr_t load;
	logic load_ack;
	logic launch_valid;
	fd_pkg::launch_t launch;
	logic [`FD_WARPS-1:0] stall;
	logic [`FD_WARPS-1:0] ib_req;
	fd_pkg::issue_t out0;
	fd_pkg::issue_t out1;

	// Model of DUT state as it stands after each rising edge
	logic [31:0] m_mem [`FD_IMEM_DEPTH];
	logic [31:0] m_pc [`FD_WARPS];
	logic [`FD_WARPS-1:0] m_active;
	logic [`FD_WARPS-1:0] m_inflight;
	int m_ptr;
	logic m_ack;
	logic f_valid [2];
	int f_warp [2];
	logic [31:0] f_pc [2];
	logic [31:0] f_instr [2];
	fd_pkg::issue_t exp_out [2];

	int errors = 0;
	int misc_errors = 0;
	int checks = 0;
	int issued = 0;
	int cycles = 0;

	fetch_decode dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.load_req(load_req),
		.load(load),
		.load_ack(load_ack),
		.launch_valid(launch_valid),
		.launch(launch),
		.stall(stall),
		.ib_req(ib_req),
		.out0(out0),
		.out1(out1)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic fd_pkg::decoded_t ref_decode(input logic [31:0] w);
		fd_pkg::decoded_t d;
		logic [5:0] op;
		logic rr;
		logic ri;
		logic st;
		logic br;
		op = w[31:26];
		rr = (op >= fd_pkg::OP_ADD) && (op <= fd_pkg::OP_OR); // Register-register group
		ri = (op == fd_pkg::OP_ADDI) || (op == fd_pkg::OP_LW);
		st = (op == fd_pkg::OP_SW);
		br = (op == fd_pkg::OP_BEQ) || (op == fd_pkg::OP_BLT);
		d = '0;
		d.dst = w[25:21];
		d.src1 = w[20:16];
		d.src2 = w[15:11];
		d.imm = w[15:0];
		if (rr)
			d.alu_op = fd_pkg::alu_op_e'(op[3:0]);
		else if (ri || st)
			d.alu_op = fd_pkg::ALU_ADD;
		else if (br)
			d.alu_op = fd_pkg::ALU_SUB;
		d.src1_valid = rr | ri | st | br;
		d.src2_valid = rr | st | br;
		d.imm_valid = ri | st | br;
		d.reg_write = rr | ri;
		d.mem_read = (op == fd_pkg::OP_LW);
		d.mem_write = st;
		d.beq = (op == fd_pkg::OP_BEQ);
		d.blt = (op == fd_pkg::OP_BLT);
		d.exit = (op == fd_pkg::OP_EXIT);
		return d;
	endfunction

	task automatic check_issue(input fd_pkg::issue_t got, input fd_pkg::issue_t exp,
		input int slot);
		checks++;
		if ((exp.valid && got !== exp) || (!exp.valid && got.valid !== 1'b0)) begin
			errors++;
			$display("Mismatch at %0t: out%0d got v=%0b warp=%h pc4=%h instr=%h dec=%h,",
				$time, slot, got.valid, got.warp, got.pc_plus4, got.instr, got.dec);
			$display("    expected v=%0b warp=%h pc4=%h instr=%h dec=%h",
				exp.valid, exp.warp, exp.pc_plus4, exp.instr, exp.dec);
		end
	endtask

	task automatic check_ack(input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: load_ack is %b, expected %b", $time, got, exp);
		end
	endtask

	// Compare, then step the model through the coming edge
	always @(negedge clk) begin
		fd_pkg::issue_t nxt [2];
		logic [`FD_WARPS-1:0] elig;
		logic [`FD_WARPS-1:0] start;
		logic [`FD_WARPS-1:0] granted;
		logic [`FD_WARPS-1:0] retire;
		logic [`FD_WARPS-1:0] kill;
		int g [2];
		int n;
		int w;
		if (!rst_n) begin
			m_active = '0;
			m_inflight = '0;
			m_ptr = 0;
			m_ack = 1'b0;
			for (int s = 0; s < 2; s++) begin
				f_valid[s] = 1'b0;
				exp_out[s] = '0;
			end
		end else begin
			check_issue(out0, exp_out[0], 0);
			check_issue(out1, exp_out[1], 1);
			check_ack(load_ack, m_ack);
			retire = '0;
			kill = '0;
			for (int s = 0; s < 2; s++) begin
				nxt[s] = '0;
				nxt[s].valid = f_valid[s];
				if (f_valid[s])
					nxt[s].warp[f_warp[s]] = 1'b1;
				nxt[s].pc_plus4 = f_pc[s] + 32'd4;
				nxt[s].instr = f_instr[s];
				nxt[s].dec = ref_decode(f_instr[s]);
				if (f_valid[s]) begin
					retire = retire | nxt[s].warp;
					issued++;
				end
				if (f_valid[s] && nxt[s].dec.exit)
					kill = kill | nxt[s].warp;
			end
			elig = m_active & ib_req & ~stall & ~m_inflight;
			n = 0;
			for (int k = 0; k < `FD_WARPS; k++) begin
				w = (m_ptr + k) % `FD_WARPS;
				if (elig[w] && n < 2) begin
					g[n] = w;
					n++;
				end
			end
			if (n > 0)
				m_ptr = (g[n-1] + 1) % `FD_WARPS;
			start = '0;
			if (launch_valid)
				start[launch.warp] = 1'b1;
			granted = '0;
			for (int s = 0; s < 2; s++) begin
				f_valid[s] = (s < n);
				if (s < n) begin
					granted[g[s]] = 1'b1;
					f_warp[s] = g[s];
					f_pc[s] = m_pc[g[s]];
					f_instr[s] = m_mem[m_pc[g[s]][`FD_IMEM_AW+1:2]]; // Old data on collision
				end
			end
			for (int v = 0; v < `FD_WARPS; v++) begin
				if (start[v])
					m_pc[v] = launch.pc;
				else if (granted[v])
					m_pc[v] = m_pc[v] + 32'd4;
			end
			m_active = start | (m_active & ~kill);
			m_inflight = ~start & (granted | (m_inflight & ~retire));
			if (load_req && !m_ack)
				m_mem[load.addr] = load.data;
			if (!m_ack && load_req)
				m_ack = 1'b1;
			else if (m_ack && !load_req)
				m_ack = 1'b0;
			exp_out = nxt;
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] rand_instr();
		logic [31:0] w;
		int sel;
		w = $urandom;
		sel = $urandom % 12;
		if (sel == 11)
			w[31:26] = 6'h3f; // Undefined opcode
		else
			w[31:26] = sel[5:0];
		return w;
	endfunction

	function automatic logic [31:0] rand_pc();
		return $urandom & 32'h0000_fffc;
	endfunction

	task automatic load_all_words();
		for (int a = 0; a < `FD_IMEM_DEPTH; a++) begin
			@(posedge clk);
			load_req <= 1'b1;
			load.addr <= a[`FD_IMEM_AW-1:0];
			load.data <= rand_instr();
			do @(negedge clk); while (!load_ack);
			@(posedge clk);
			load_req <= 1'b0;
			do @(negedge clk); while (load_ack);
		end
	endtask

	task automatic launch_all_warps();
		for (int w = 0; w < `FD_WARPS; w++) begin
			@(posedge clk);
			launch_valid <= 1'b1;
			launch <= '{warp: w[WW-1:0], pc: rand_pc()};
		end
		@(posedge clk);
		launch_valid <= 1'b0;
	endtask

	task automatic run_traffic(input int n, input logic masked, input int relaunch_div);
		logic [31:0] r;
		int w;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			launch_valid <= 1'b0;
			if (masked) begin
				r = $urandom;
				stall <= r[`FD_WARPS-1:0];
				r = $urandom;
				ib_req <= r[`FD_WARPS-1:0];
			end else begin
				stall <= '0;
				ib_req <= '1;
			end
			if (relaunch_div > 0 && ($urandom % relaunch_div) == 0) begin
				w = $urandom % `FD_WARPS;
				launch_valid <= 1'b1;
				launch <= '{warp: w[WW-1:0], pc: rand_pc()};
			end
		end
		@(posedge clk);
		launch_valid <= 1'b0;
	endtask

	task automatic report_test(input string name, input int err_mark, input int iss_mark);
		if (iss_mark >= 0 && issued == iss_mark) begin
			misc_errors++;
			$display("No instruction was issued during %s", name);
		end
		$display("%s finished with %0d errors", name, errors + misc_errors - err_mark);
	endtask

	initial begin
		int err_mark;
		int iss_mark;
		void'($urandom(94618));
		rst_n = 1'b0;
		load_req = 1'b0;
		load = '0;
		launch_valid = 1'b0;
		launch = '0;
		stall = '0;
		ib_req = '1;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		err_mark = errors + misc_errors;
		load_all_words();
		report_test("Load handshake", err_mark, -1);

		err_mark = errors + misc_errors;
		iss_mark = issued;
		launch_all_warps();
		run_traffic(RUN_CYC, 1'b0, 0);
		report_test("Decode, PC and rotation", err_mark, iss_mark);

		err_mark = errors + misc_errors;
		iss_mark = issued;
		launch_all_warps();
		run_traffic(MASK_CYC, 1'b1, 16);
		report_test("Stall and ib_req masking", err_mark, iss_mark);

		err_mark = errors + misc_errors;
		iss_mark = issued;
		launch_all_warps();
		run_traffic(EXIT_CYC, 1'b0, 4);
		report_test("Exit and relaunch", err_mark, iss_mark);

		@(posedge clk);
		ib_req <= '0; // Let in-flight work drain
		repeat (6) @(posedge clk);
		$display("Summary: %0d checks, %0d outputs, %0d errors",
			checks, issued, errors + misc_errors);
		if (errors + misc_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
